// ==== Makefile ====
# Verilator flow for the UART debug bridge

VERILATOR ?= verilator
TOP       ?= tb_uart_bus_top
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
verilog/uart_bus_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/uart_bus_bridge.sv
verilog/bus_memory.sv
verilog/uart_bus_top.sv
tb/tb_uart_bus_top.sv

// ==== tb/tb_uart_bus_top.sv ====
`timescale 1ns/1ps

module tb_uart_bus_top;
    import uart_bus_pkg::*;

    localparam int REPLY_TIMEOUT = 20 * CLKS_PER_BIT;
    localparam int WRITE_GAP     = 2 * FRAME_BITS * CLKS_PER_BIT;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_JUNK
    } op_kind_t;

    typedef struct packed {
        op_kind_t  kind;
        bus_word_t addr;
        bus_word_t data;
        bus_word_t expected;
    } op_t;

    logic      clk50MHz;
    logic      rst;
    logic      rx;
    logic      tx;
    logic      reply_window;
    bus_word_t rng_state;
    bus_word_t shadow [MEM_WORDS];
    op_t       ops [$];

    uart_bus_top i_dut (
        .clk50MHz (clk50MHz),
        .rst      (rst),
        .rx       (rx),
        .tx       (tx)
    );

    always #10 clk50MHz = ~clk50MHz;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // Any start bit outside a read reply is an error
    always @(negedge clk50MHz) begin
        if (!rst && !reply_window) begin
            assert (tx) else abort_run("tx went low while no reply was expected");
        end
    end

    function automatic bus_word_t xorshift(input bus_word_t x);
        bus_word_t y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic bus_word_t random_word();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Expected reads follow the memory rule: word index is the low address byte
    task automatic push_op(input op_kind_t kind, input bus_word_t addr, input bus_word_t data);
        op_t op;
        op.kind     = kind;
        op.addr     = addr;
        op.data     = data;
        op.expected = '0;
        if (kind == OP_WRITE) begin
            shadow[addr[7:0]] = data;
        end else if (kind == OP_READ) begin
            op.expected = shadow[addr[7:0]];
        end
        ops.push_back(op);
    endtask

    task automatic build_table();
        push_op(OP_WRITE, 32'h0000_0010, 32'h1234_5678);
        push_op(OP_READ,  32'h0000_0010, '0);
        // Junk ahead of a frame
        push_op(OP_JUNK,  '0, 32'h0000_00a5);
        push_op(OP_JUNK,  '0, 32'h0000_0000);
        push_op(OP_JUNK,  '0, 32'h0000_00ff);
        push_op(OP_WRITE, 32'h0000_0020, 32'hcafe_f00d);
        push_op(OP_READ,  32'h0000_0020, '0);
        // Aliasing through the upper 24 bits
        push_op(OP_WRITE, 32'h0000_0042, 32'hdead_beef);
        push_op(OP_READ,  32'habcd_ef42, '0);
        push_op(OP_WRITE, 32'h0000_0005, random_word());
        push_op(OP_WRITE, 32'h0000_0080, random_word());
        push_op(OP_WRITE, 32'h0000_00ff, random_word());
        push_op(OP_WRITE, 32'h0000_007f, random_word());
        push_op(OP_WRITE, 32'h0000_0005, random_word());
        push_op(OP_READ,  32'h0000_007f, '0);
        push_op(OP_READ,  32'h0000_00ff, '0);
        push_op(OP_READ,  32'h1234_5605, '0);
        push_op(OP_READ,  32'h0000_0080, '0);
        push_op(OP_READ,  32'h0000_0010, '0);
    endtask

    // Start, eight data bits LSB first, stop
    task automatic send_byte(input uart_byte_t b);
        logic [FRAME_BITS-1:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < FRAME_BITS; i++) begin
            @(posedge clk50MHz);
            rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk50MHz);
        end
    endtask

    task automatic send_frame(input uart_byte_t cmd, input bus_word_t addr,
                              input bus_word_t data, input logic with_data);
        send_byte(cmd);
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            send_byte(addr[8*i +: 8]);
        end
        if (with_data) begin
            for (int i = 0; i < BYTES_PER_WORD; i++) begin
                send_byte(data[8*i +: 8]);
            end
        end
    endtask

    task automatic recv_byte(output uart_byte_t b);
        int waited;
        waited = 0;
        while (tx && waited < REPLY_TIMEOUT) begin
            @(negedge clk50MHz);
            waited++;
        end
        assert (!tx) else abort_run("timeout waiting for a reply start bit on tx");
        repeat (CLKS_PER_BIT / 2) @(negedge clk50MHz);
        assert (!tx) else abort_run("start bit on tx ended before mid-bit");
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk50MHz);
            b[i] = tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk50MHz);
        assert (tx) else abort_run("stop bit on tx was low");
    endtask

    task automatic run_op(input op_t op);
        uart_byte_t b;
        bus_word_t  got;
        case (op.kind)
            OP_JUNK: begin
                send_byte(op.data[7:0]);
            end
            OP_WRITE: begin
                send_frame(CMD_WRITE, op.addr, op.data, 1'b1);
                repeat (WRITE_GAP) @(negedge clk50MHz);
            end
            default: begin
                reply_window = 1'b1;
                send_frame(CMD_READ, op.addr, '0, 1'b0);
                for (int i = 0; i < BYTES_PER_WORD; i++) begin
                    recv_byte(b);
                    got[8*i +: 8] = b;
                end
                reply_window = 1'b0;
                assert (got == op.expected) else abort_run($sformatf(
                    "mismatch read_word at addr %h: got %h, expected %h",
                    op.addr, got, op.expected));
            end
        endcase
    endtask

    initial begin
        clk50MHz     = 1'b0;
        rst          = 1'b1;
        rx           = 1'b1;
        reply_window = 1'b0;
        rng_state    = 32'hed07;
        build_table();

        repeat (10) @(posedge clk50MHz);
        rst <= 1'b0;

        // Quiet line after reset
        repeat (200 * CLKS_PER_BIT) @(negedge clk50MHz);

        foreach (ops[i]) begin
            run_op(ops[i]);
        end
        repeat (WRITE_GAP) @(negedge clk50MHz);

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== verilog/bus_memory.sv ====
`timescale 1ns/1ps

module bus_memory (
    input  logic                    clk50MHz,
    input  logic                    rst,
    input  logic                    bus_req,
    output logic                    bus_ack,
    input  logic                    bus_we,
    output logic                    bus_wait,
    input  uart_bus_pkg::bus_word_t bus_wdata,
    output uart_bus_pkg::bus_word_t bus_rdata
);
    import uart_bus_pkg::*;

    mem_state_t state;
    wait_cnt_t  wait_cnt;
    mem_index_t index;
    bus_word_t  mem [MEM_WORDS];

    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            state    <= MEM_IDLE;
            wait_cnt <= '0;
        end else begin
            case (state)
                MEM_IDLE: begin
                    if (bus_req) begin
                        state <= MEM_LATCH;
                    end
                end
                MEM_LATCH: begin
                    wait_cnt <= '0;
                    state    <= MEM_WAIT;
                end
                MEM_WAIT: begin
                    if (wait_cnt == WAIT_LAST) begin
                        state <= MEM_DATA;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                MEM_DATA: begin
                    state <= MEM_IDLE;
                end
                default: begin
                    state <= MEM_IDLE;
                end
            endcase
        end
    end

    // Upper address bits are ignored, so addresses alias every 256 words
    always_ff @(posedge clk50MHz) begin
        if (state == MEM_LATCH) begin
            index <= bus_wdata[$bits(mem_index_t)-1:0];
        end
        if (state == MEM_DATA && bus_we) begin
            mem[index] <= bus_wdata;
        end
        bus_rdata <= mem[index];
    end

    assign bus_ack = (state == MEM_IDLE) && bus_req;

    // High for the address cycle and all but the last wait cycle
    assign bus_wait = (state == MEM_LATCH) ||
                      ((state == MEM_WAIT) && (wait_cnt != WAIT_LAST));

endmodule

// ==== verilog/uart_bus_bridge.sv ====
`timescale 1ns/1ps

module uart_bus_bridge (
    input  logic                     clk50MHz,
    input  logic                     rst,
    input  uart_bus_pkg::uart_byte_t rx_data,
    input  logic                     rx_valid,
    output uart_bus_pkg::uart_byte_t tx_data,
    output logic                     tx_valid,
    input  logic                     tx_busy,
    output logic                     bus_req,
    input  logic                     bus_ack,
    output logic                     bus_we,
    input  logic                     bus_wait,
    output uart_bus_pkg::bus_word_t  bus_wdata,
    input  uart_bus_pkg::bus_word_t  bus_rdata
);
    import uart_bus_pkg::*;

    bridge_state_t state;
    bridge_state_t next_state;
    logic          is_write;
    byte_cnt_t     byte_cnt;
    bus_word_t     addr;
    bus_word_t     wdata;
    bus_word_t     rdata;
    logic          is_cmd;
    logic          last_byte;
    logic          rx_addr_byte;
    logic          rx_data_byte;
    logic          byte_step;

    assign is_cmd       = (rx_data == CMD_READ) || (rx_data == CMD_WRITE);
    assign last_byte    = (byte_cnt == BYTE_LAST);
    assign rx_addr_byte = (state == ST_RX_ADDR) && rx_valid;
    assign rx_data_byte = (state == ST_RX_DATA) && rx_valid;
    assign byte_step    = rx_addr_byte || rx_data_byte || tx_valid;

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (rx_valid && is_cmd) begin
                    next_state = ST_RX_ADDR;
                end
            end
            ST_RX_ADDR: begin
                if (rx_valid && last_byte) begin
                    next_state = is_write ? ST_RX_DATA : ST_BUS_REQ;
                end
            end
            ST_RX_DATA: begin
                if (rx_valid && last_byte) begin
                    next_state = ST_BUS_REQ;
                end
            end
            ST_BUS_REQ: begin
                if (bus_ack) begin
                    next_state = ST_BUS_ADDR;
                end
            end
            ST_BUS_ADDR: begin
                next_state = ST_BUS_WAIT;
            end
            ST_BUS_WAIT: begin
                if (!bus_wait) begin
                    next_state = is_write ? ST_BUS_WRITE : ST_BUS_READ;
                end
            end
            ST_BUS_WRITE: begin
                next_state = ST_BUS_FINISH;
            end
            ST_BUS_READ: begin
                next_state = ST_BUS_FINISH;
            end
            ST_BUS_FINISH: begin
                next_state = is_write ? ST_IDLE : ST_TX_REPLY;
            end
            ST_TX_REPLY: begin
                if (tx_valid && last_byte) begin
                    next_state = ST_IDLE;
                end
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            state    <= ST_IDLE;
            is_write <= 1'b0;
            byte_cnt <= '0;
        end else begin
            state <= next_state;
            if (state == ST_IDLE) begin
                byte_cnt <= '0;
                if (rx_valid) begin
                    is_write <= (rx_data == CMD_WRITE);
                end
            end else if (byte_step) begin
                // Wraps back to zero after the last byte of a word
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    // Words are assembled LSB first
    always_ff @(posedge clk50MHz) begin
        if (rx_addr_byte) begin
            addr[BYTE_WIDTH*byte_cnt +: BYTE_WIDTH] <= rx_data;
        end
        if (rx_data_byte) begin
            wdata[BYTE_WIDTH*byte_cnt +: BYTE_WIDTH] <= rx_data;
        end
        if (state == ST_BUS_READ) begin
            rdata <= bus_rdata;
        end
    end

    assign bus_req = (state == ST_BUS_REQ)   ||
                     (state == ST_BUS_ADDR)  ||
                     (state == ST_BUS_WAIT)  ||
                     (state == ST_BUS_WRITE) ||
                     (state == ST_BUS_READ);

    assign bus_we = is_write;

    // Address on the shared lines for one cycle only
    assign bus_wdata = (state == ST_BUS_ADDR) ? addr : wdata;

    assign tx_valid = (state == ST_TX_REPLY) && !tx_busy;
    assign tx_data  = rdata[BYTE_WIDTH*byte_cnt +: BYTE_WIDTH];

endmodule

// ==== verilog/uart_bus_pkg.sv ====
package uart_bus_pkg;

    // Bus and serial widths
    localparam int BUS_WIDTH      = 32;
    localparam int BYTE_WIDTH     = 8;
    localparam int BYTES_PER_WORD = 4;
    localparam int BYTE_CNT_WIDTH = $clog2(BYTES_PER_WORD);

    typedef logic [BUS_WIDTH-1:0]          bus_word_t;
    typedef logic [BYTE_WIDTH-1:0]         uart_byte_t;
    typedef logic [BYTE_CNT_WIDTH-1:0]     byte_cnt_t;
    typedef logic [$clog2(BYTE_WIDTH)-1:0] bit_idx_t;

    localparam byte_cnt_t BYTE_LAST = byte_cnt_t'(BYTES_PER_WORD - 1);

    // Host protocol
    localparam uart_byte_t CMD_READ  = 8'h55;
    localparam uart_byte_t CMD_WRITE = 8'h56;

    // Serial timing, start + 8 data + stop
    localparam int CLKS_PER_BIT = 16;
    localparam int FRAME_BITS   = 10;

    typedef logic [$clog2(CLKS_PER_BIT)-1:0] bit_timer_t;
    typedef logic [$clog2(FRAME_BITS)-1:0]   frame_cnt_t;

    localparam bit_timer_t BIT_LAST      = bit_timer_t'(CLKS_PER_BIT - 1);
    localparam bit_timer_t HALF_BIT_LAST = bit_timer_t'(CLKS_PER_BIT / 2 - 1);
    localparam frame_cnt_t FRAME_LAST    = frame_cnt_t'(FRAME_BITS - 1);

    // Memory slave
    localparam int MEM_WAIT_CYCLES = 3;
    localparam int MEM_WORDS       = 256;

    typedef logic [$clog2(MEM_WORDS)-1:0]       mem_index_t;
    typedef logic [$clog2(MEM_WAIT_CYCLES)-1:0] wait_cnt_t;

    localparam wait_cnt_t WAIT_LAST = wait_cnt_t'(MEM_WAIT_CYCLES - 1);

    // State machines
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_LATCH,
        MEM_WAIT,
        MEM_DATA
    } mem_state_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_RX_ADDR,
        ST_RX_DATA,
        ST_BUS_REQ,
        ST_BUS_ADDR,
        ST_BUS_WAIT,
        ST_BUS_WRITE,
        ST_BUS_READ,
        ST_BUS_FINISH,
        ST_TX_REPLY
    } bridge_state_t;

endpackage

// ==== verilog/uart_bus_top.sv ====
`timescale 1ns/1ps

module uart_bus_top (
    input  logic clk50MHz,
    input  logic rst,
    input  logic rx,
    output logic tx
);
    import uart_bus_pkg::*;

    uart_byte_t rx_data;
    logic       rx_valid;
    uart_byte_t tx_data;
    logic       tx_valid;
    logic       tx_busy;
    logic       bus_req;
    logic       bus_ack;
    logic       bus_we;
    logic       bus_wait;
    bus_word_t  bus_wdata;
    bus_word_t  bus_rdata;

    uart_rx i_rx (
        .clk50MHz (clk50MHz),
        .rst      (rst),
        .rx       (rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    uart_tx i_tx (
        .clk50MHz (clk50MHz),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

    uart_bus_bridge i_bridge (
        .clk50MHz  (clk50MHz),
        .rst       (rst),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_busy   (tx_busy),
        .bus_req   (bus_req),
        .bus_ack   (bus_ack),
        .bus_we    (bus_we),
        .bus_wait  (bus_wait),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata)
    );

    bus_memory i_mem (
        .clk50MHz  (clk50MHz),
        .rst       (rst),
        .bus_req   (bus_req),
        .bus_ack   (bus_ack),
        .bus_we    (bus_we),
        .bus_wait  (bus_wait),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata)
    );

endmodule

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic                     clk50MHz,
    input  logic                     rst,
    input  logic                     rx,
    output uart_bus_pkg::uart_byte_t rx_data,
    output logic                     rx_valid
);
    import uart_bus_pkg::*;

    logic       rx_meta;
    logic       rx_sync;
    rx_state_t  state;
    bit_timer_t clk_cnt;
    bit_idx_t   bit_cnt;
    uart_byte_t shift;

    // Line idles high
    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (clk_cnt == HALF_BIT_LAST) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        // Start bit gone by mid-bit is a glitch
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == BIT_LAST) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == bit_idx_t'(BYTE_WIDTH - 1)) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == BIT_LAST) begin
                        // Framing error drops the byte
                        rx_valid <= rx_sync;
                        state    <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk50MHz) begin
        if (state == RX_DATA && clk_cnt == BIT_LAST) begin
            shift <= {rx_sync, shift[BYTE_WIDTH-1:1]};
        end
    end

    assign rx_data = shift;

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic                     clk50MHz,
    input  logic                     rst,
    input  uart_bus_pkg::uart_byte_t tx_data,
    input  logic                     tx_valid,
    output logic                     tx,
    output logic                     tx_busy
);
    import uart_bus_pkg::*;

    logic [FRAME_BITS-1:0] frame;
    bit_timer_t            clk_cnt;
    frame_cnt_t            bit_cnt;

    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            frame   <= '1;
            clk_cnt <= '0;
            bit_cnt <= '0;
            tx_busy <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_valid) begin
                // Stop bit, data LSB first, start bit
                frame   <= {1'b1, tx_data, 1'b0};
                clk_cnt <= '0;
                bit_cnt <= '0;
                tx_busy <= 1'b1;
            end
        end else begin
            if (clk_cnt == BIT_LAST) begin
                clk_cnt <= '0;
                frame   <= {1'b1, frame[FRAME_BITS-1:1]};
                if (bit_cnt == FRAME_LAST) begin
                    tx_busy <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    // Ones shift in behind the frame, so the line rests high
    assign tx = frame[0];

endmodule
